// File: ht_cfg_pkg.sv
//--------------------
// table sizing defaults for the hash table init path
// widths are address widths, depths are 2**width
// the top level overrides these through its parameters
//--------------------

package ht_cfg_pkg;

  //--------------------
  // address widths
  //--------------------

  // data table, one entry per record
  localparam int TABLE_ADDR_WIDTH = 5;

  // head table, one entry per bucket
  localparam int BUCKET_WIDTH_DEF = 4;

  //--------------------
  // payload
  //--------------------

  // width of one data table record
  localparam int DATA_WIDTH = 32;

endpackage

// File: ht_cmd_pkg.sv
//--------------------
// command and result words of the hash table
// only OP_INIT is served by this design, other codes are kept
// so that the encodings match the full engine
//--------------------

package ht_cmd_pkg;
  import ht_cfg_pkg::*;

  localparam int KEY_WIDTH = 16;

  //--------------------
  // encodings
  //--------------------

  typedef enum logic [1:0] {
    OP_SEARCH = 2'd0,
    OP_INSERT = 2'd1,
    OP_DELETE = 2'd2,
    OP_INIT   = 2'd3
  } ht_cmd_t;

  typedef enum logic [1:0] {
    INIT_SUCCESS     = 2'd0,
    SEARCH_FOUND     = 2'd1,
    SEARCH_NOT_FOUND = 2'd2,
    NO_SPACE         = 2'd3
  } ht_rescode_t;

  //--------------------
  // task and result words
  //--------------------

  // key is carried along but not looked at by init
  typedef struct packed {
    ht_cmd_t              cmd;
    logic [KEY_WIDTH-1:0] key;
  } ht_pdata_t;

  // bucket is zero for init
  typedef struct packed {
    ht_cmd_t                     cmd;
    ht_rescode_t                 rescode;
    logic [BUCKET_WIDTH_DEF-1:0] bucket;
  } ht_result_t;

endpackage

// File: ht_ifs.sv
//--------------------
// interfaces between the init engine, the tables and the result port
// writes are plain levels, sampled on every clock edge
// result moves on the edge where valid and ready are both high
//--------------------

// bucket head write port
interface head_table_if #(
  parameter int BUCKET_WIDTH = 4,
  parameter int A_WIDTH      = 5
);
  logic [BUCKET_WIDTH-1:0] wr_addr;
  logic [A_WIDTH-1:0]      wr_data_ptr;
  logic                    wr_data_ptr_val;
  logic                    wr_en;

  modport master (
    output wr_addr, wr_data_ptr, wr_data_ptr_val, wr_en
  );

  modport slave (
    input  wr_addr, wr_data_ptr, wr_data_ptr_val, wr_en
  );
endinterface

// record port, table side only takes the write half
interface data_table_if
  import ht_cfg_pkg::*;
#(
  parameter int A_WIDTH = 5
);
  logic [A_WIDTH-1:0]    wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  wr_en;
  logic                  rd_en;
  logic [A_WIDTH-1:0]    rd_addr;

  modport master (
    output wr_addr, wr_data, wr_en, rd_en, rd_addr
  );

  modport slave (
    input  wr_addr, wr_data, wr_en
  );
endinterface

// result handshake
interface ht_res_if
  import ht_cmd_pkg::*;
;
  ht_result_t result;
  logic       valid;
  logic       ready;

  modport master (
    output result, valid,
    input  ready
  );

  modport slave (
    input  result, valid,
    output ready
  );
endinterface

// File: data_table_init.sv
//--------------------
// init engine: clears head and data tables, refills the free list
// every accepted command runs an init, cmd is only echoed back
// latency is max(2**A_WIDTH, 2**BUCKET_WIDTH) + 2 cycles to result
//--------------------

module data_table_init
  import ht_cfg_pkg::*;
  import ht_cmd_pkg::*;
#(
  parameter int A_WIDTH      = TABLE_ADDR_WIDTH,
  parameter int BUCKET_WIDTH = BUCKET_WIDTH_DEF
) (
  input  logic               clk_i,
  input  logic               rst_i,

  input  ht_pdata_t          task_i,
  input  logic               task_valid_i,
  output logic               task_ready_o,

  data_table_if.master       data_table_if,
  head_table_if.master       head_table_if,

  // free list refill
  output logic               empty_ptr_storage_srst_o,
  output logic [A_WIDTH-1:0] add_empty_ptr_o,
  output logic               add_empty_ptr_en_o,

  ht_res_if.master           ht_res_if
);

  localparam int CNT_W = (BUCKET_WIDTH > A_WIDTH) ? BUCKET_WIDTH : A_WIDTH;

  enum logic [1:0] {
    IDLE_S,
    RESET_S,
    INIT_S,
    REPORT_S
  } state, next_state;

  ht_cmd_t          cmd_locked;
  logic [CNT_W-1:0] cnt_addr;
  logic             head_done;
  logic             data_done;

  //--------------------
  // FSM
  //--------------------

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state <= IDLE_S;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE_S:
        if (task_valid_i)
          next_state = RESET_S;
      // one cycle of srst to the free list
      RESET_S:
        next_state = INIT_S;
      INIT_S:
        if (head_done && data_done)
          next_state = REPORT_S;
      REPORT_S:
        if (ht_res_if.ready)
          next_state = IDLE_S;
      default:
        next_state = IDLE_S;
    endcase
  end

  assign task_ready_o = (state == IDLE_S);

  always_ff @(posedge clk_i)
  begin
    if (task_valid_i && task_ready_o)
      cmd_locked <= task_i.cmd;
  end

  //--------------------
  // address sweep
  //--------------------

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      cnt_addr <= '0;
    else if (state != INIT_S)
      cnt_addr <= '0;
    else
      cnt_addr <= cnt_addr + 1'b1;
  end

  // each flag rises after its table's last address is written
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      head_done <= 1'b0;
      data_done <= 1'b0;
    end
    else if (state != INIT_S)
    begin
      head_done <= 1'b0;
      data_done <= 1'b0;
    end
    else
    begin
      if (head_table_if.wr_en && (head_table_if.wr_addr == '1))
        head_done <= 1'b1;
      if (data_table_if.wr_en && (data_table_if.wr_addr == '1))
        data_done <= 1'b1;
    end
  end

  assign head_table_if.wr_addr         = cnt_addr[BUCKET_WIDTH-1:0];
  assign head_table_if.wr_data_ptr     = '0;
  assign head_table_if.wr_data_ptr_val = 1'b0;
  assign head_table_if.wr_en           = (state == INIT_S) && !head_done;

  assign data_table_if.wr_addr = cnt_addr[A_WIDTH-1:0];
  assign data_table_if.wr_data = '0;
  assign data_table_if.wr_en   = (state == INIT_S) && !data_done;
  // read half is not used by init
  assign data_table_if.rd_en   = 1'b0;
  assign data_table_if.rd_addr = '0;

  // every cleared record goes back on the free list
  assign empty_ptr_storage_srst_o = (state == RESET_S);
  assign add_empty_ptr_o          = data_table_if.wr_addr;
  assign add_empty_ptr_en_o       = data_table_if.wr_en;

  //--------------------
  // report
  //--------------------

  always_comb
  begin
    ht_res_if.result = '{cmd: cmd_locked, rescode: INIT_SUCCESS, bucket: '0};
  end

  assign ht_res_if.valid = (state == REPORT_S);

endmodule

// File: head_table.sv
//--------------------
// bucket head RAM, one pointer and valid bit per bucket
// init write beats a host write in the same cycle
// read data appears one cycle after the address
//--------------------

module head_table
  import ht_cfg_pkg::*;
#(
  parameter int A_WIDTH      = TABLE_ADDR_WIDTH,
  parameter int BUCKET_WIDTH = BUCKET_WIDTH_DEF
) (
  input  logic                    clk_i,

  head_table_if.slave             init_if,

  input  logic [BUCKET_WIDTH-1:0] host_wr_addr_i,
  input  logic [A_WIDTH-1:0]      host_wr_ptr_i,
  input  logic                    host_wr_ptr_val_i,
  input  logic                    host_wr_en_i,

  input  logic [BUCKET_WIDTH-1:0] rd_addr_i,
  output logic [A_WIDTH-1:0]      rd_ptr_o,
  output logic                    rd_ptr_val_o
);

  localparam int DEPTH = 2**BUCKET_WIDTH;

  // entry is {valid, ptr}
  logic [A_WIDTH:0] mem [DEPTH];
  logic [A_WIDTH:0] rd_q;

  always_ff @(posedge clk_i)
  begin
    if (init_if.wr_en)
      mem[init_if.wr_addr] <= {init_if.wr_data_ptr_val, init_if.wr_data_ptr};
    else if (host_wr_en_i)
      mem[host_wr_addr_i] <= {host_wr_ptr_val_i, host_wr_ptr_i};
    rd_q <= mem[rd_addr_i];
  end

  assign rd_ptr_o     = rd_q[A_WIDTH-1:0];
  assign rd_ptr_val_o = rd_q[A_WIDTH];

endmodule

// File: data_table.sv
//--------------------
// record RAM, DATA_WIDTH bits per entry
// init write beats a host write in the same cycle
// rd_data_o holds until the next read enable
//--------------------

module data_table
  import ht_cfg_pkg::*;
#(
  parameter int A_WIDTH = TABLE_ADDR_WIDTH
) (
  input  logic                  clk_i,

  data_table_if.slave           init_if,

  input  logic [A_WIDTH-1:0]    host_wr_addr_i,
  input  logic [DATA_WIDTH-1:0] host_wr_data_i,
  input  logic                  host_wr_en_i,

  input  logic [A_WIDTH-1:0]    rd_addr_i,
  input  logic                  rd_en_i,
  output logic [DATA_WIDTH-1:0] rd_data_o
);

  localparam int DEPTH = 2**A_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // write side
  always_ff @(posedge clk_i)
  begin
    if (init_if.wr_en)
      mem[init_if.wr_addr] <= init_if.wr_data;
    else if (host_wr_en_i)
      mem[host_wr_addr_i] <= host_wr_data_i;
  end

  // registered read
  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
      rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: empty_ptr_storage.sv
//--------------------
// FIFO of free data table addresses, depth 2**A_WIDTH
// srst_i empties it; add when full and get when empty are ignored
// head entry is shown combinationally, get_i pops on the edge
//--------------------

module empty_ptr_storage
  import ht_cfg_pkg::*;
#(
  parameter int A_WIDTH = TABLE_ADDR_WIDTH
) (
  input  logic               clk_i,
  input  logic               rst_i,

  input  logic               srst_i,
  input  logic [A_WIDTH-1:0] add_ptr_i,
  input  logic               add_en_i,

  input  logic               get_i,
  output logic [A_WIDTH-1:0] ptr_o,
  output logic               ptr_val_o
);

  localparam int DEPTH = 2**A_WIDTH;

  logic [A_WIDTH-1:0] mem [DEPTH];
  logic [A_WIDTH-1:0] wr_ptr;
  logic [A_WIDTH-1:0] rd_ptr;
  logic [A_WIDTH:0]   count;
  logic               full;
  logic               empty;
  logic               do_add;
  logic               do_get;

  assign full   = (count == DEPTH[A_WIDTH:0]);
  assign empty  = (count == '0);
  assign do_add = add_en_i && !full;
  assign do_get = get_i && !empty;

  //--------------------
  // pointers and count
  //--------------------

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (srst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_add)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_get)
        rd_ptr <= rd_ptr + 1'b1;
      // add and get together leave the count as is
      if (do_add && !do_get)
        count <= count + 1'b1;
      else if (do_get && !do_add)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_i)
  begin
    if (do_add && !srst_i)
      mem[wr_ptr] <= add_ptr_i;
  end

  assign ptr_o     = mem[rd_ptr];
  assign ptr_val_o = !empty;

endmodule

// File: hash_table_init_top.sv
//--------------------
// top of the hash table init path, plain ports only
// any offered command starts an init; result echoes the cmd
// host ports reach the tables for preload and readback
//--------------------

module hash_table_init_top
  import ht_cfg_pkg::*;
  import ht_cmd_pkg::*;
#(
  parameter int A_WIDTH      = TABLE_ADDR_WIDTH,
  parameter int BUCKET_WIDTH = BUCKET_WIDTH_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // task
  input  ht_cmd_t                 task_cmd_i,
  input  logic [KEY_WIDTH-1:0]    task_key_i,
  input  logic                    task_valid_i,
  output logic                    task_ready_o,

  // result
  output ht_cmd_t                 result_cmd_o,
  output ht_rescode_t             result_rescode_o,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,

  // head table host side
  input  logic [BUCKET_WIDTH-1:0] head_wr_addr_i,
  input  logic [A_WIDTH-1:0]      head_wr_ptr_i,
  input  logic                    head_wr_ptr_val_i,
  input  logic                    head_wr_en_i,
  input  logic [BUCKET_WIDTH-1:0] head_rd_addr_i,
  output logic [A_WIDTH-1:0]      head_rd_ptr_o,
  output logic                    head_rd_ptr_val_o,

  // data table host side
  input  logic [A_WIDTH-1:0]      data_wr_addr_i,
  input  logic [DATA_WIDTH-1:0]   data_wr_data_i,
  input  logic                    data_wr_en_i,
  input  logic [A_WIDTH-1:0]      data_rd_addr_i,
  input  logic                    data_rd_en_i,
  output logic [DATA_WIDTH-1:0]   data_rd_data_o,

  // free list
  input  logic                    empty_get_i,
  output logic [A_WIDTH-1:0]      empty_ptr_o,
  output logic                    empty_ptr_val_o
);

  ht_pdata_t          task_w;
  logic               eps_srst;
  logic [A_WIDTH-1:0] eps_add_ptr;
  logic               eps_add_en;

  head_table_if #(.BUCKET_WIDTH(BUCKET_WIDTH), .A_WIDTH(A_WIDTH)) head_if ();
  data_table_if #(.A_WIDTH(A_WIDTH))                              data_if ();
  ht_res_if                                                       res_if ();

  assign task_w = '{cmd: task_cmd_i, key: task_key_i};

  assign result_cmd_o     = res_if.result.cmd;
  assign result_rescode_o = res_if.result.rescode;
  assign result_valid_o   = res_if.valid;
  assign res_if.ready     = result_ready_i;

  data_table_init #(
    .A_WIDTH      (A_WIDTH),
    .BUCKET_WIDTH (BUCKET_WIDTH)
  ) u_data_table_init (
    .clk_i                    (clk_i),
    .rst_i                    (rst_i),
    .task_i                   (task_w),
    .task_valid_i             (task_valid_i),
    .task_ready_o             (task_ready_o),
    .data_table_if            (data_if.master),
    .head_table_if            (head_if.master),
    .empty_ptr_storage_srst_o (eps_srst),
    .add_empty_ptr_o          (eps_add_ptr),
    .add_empty_ptr_en_o       (eps_add_en),
    .ht_res_if                (res_if.master)
  );

  head_table #(
    .A_WIDTH      (A_WIDTH),
    .BUCKET_WIDTH (BUCKET_WIDTH)
  ) u_head_table (
    .clk_i             (clk_i),
    .init_if           (head_if.slave),
    .host_wr_addr_i    (head_wr_addr_i),
    .host_wr_ptr_i     (head_wr_ptr_i),
    .host_wr_ptr_val_i (head_wr_ptr_val_i),
    .host_wr_en_i      (head_wr_en_i),
    .rd_addr_i         (head_rd_addr_i),
    .rd_ptr_o          (head_rd_ptr_o),
    .rd_ptr_val_o      (head_rd_ptr_val_o)
  );

  data_table #(
    .A_WIDTH (A_WIDTH)
  ) u_data_table (
    .clk_i          (clk_i),
    .init_if        (data_if.slave),
    .host_wr_addr_i (data_wr_addr_i),
    .host_wr_data_i (data_wr_data_i),
    .host_wr_en_i   (data_wr_en_i),
    .rd_addr_i      (data_rd_addr_i),
    .rd_en_i        (data_rd_en_i),
    .rd_data_o      (data_rd_data_o)
  );

  empty_ptr_storage #(
    .A_WIDTH (A_WIDTH)
  ) u_empty_ptr_storage (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .srst_i    (eps_srst),
    .add_ptr_i (eps_add_ptr),
    .add_en_i  (eps_add_en),
    .get_i     (empty_get_i),
    .ptr_o     (empty_ptr_o),
    .ptr_val_o (empty_ptr_val_o)
  );

endmodule

// File: hash_table_init_props.sv
//--------------------
// assertions bound into data_table_init
// result word is sampled as a whole for the hold check
//--------------------

module hash_table_init_props
  import ht_cmd_pkg::*;
#(
  parameter int A_WIDTH = 5
) (
  input logic               clk_i,
  input logic               rst_i,
  input logic               srst_i,
  input logic               head_wr_en_i,
  input logic               data_wr_en_i,
  input logic [A_WIDTH-1:0] data_wr_addr_i,
  input logic               add_en_i,
  input logic [A_WIDTH-1:0] add_ptr_i,
  input logic               res_valid_i,
  input logic               res_ready_i,
  input ht_result_t         res_result_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // single clear pulse, refill starts at address 0 on the next cycle
  srst_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    srst_i |=> (!srst_i && add_en_i && (add_ptr_i == '0)))
    else $error("free list clear not a single pulse followed by a refill from 0");

  // result held until the host takes it
  result_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_result_i)))
    else $error("result dropped or changed before ready");

  // every head or data clear comes with a free list add
  add_mirrors_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (head_wr_en_i || data_wr_en_i) |-> (add_en_i && (add_ptr_i == data_wr_addr_i)))
    else $error("init table write without matching free list add");

endmodule

// File: tb_hash_table_init.sv
//--------------------
// testbench for the hash table init path at default table sizes
// steps come from a table and inputs change on the falling edge
// a cycle counter ends a run that hangs
//--------------------

module tb_hash_table_init
  import ht_cfg_pkg::*;
  import ht_cmd_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int A_W         = TABLE_ADDR_WIDTH;
  localparam int B_W         = BUCKET_WIDTH_DEF;
  localparam int H_DEPTH     = 2**B_W;
  localparam int D_DEPTH     = 2**A_W;
  localparam int NUM_STEPS   = 10;
  localparam int MAX_DELAY   = 16;
  localparam int MARGIN      = 20;
  localparam int ROW_CYCLES  = 3 * (H_DEPTH + D_DEPTH) + MAX_DELAY + MARGIN;
  localparam int CYCLE_LIMIT = NUM_STEPS * ROW_CYCLES;

  typedef enum {K_PREFILL, K_DELAY, K_INIT, K_BUSY, K_POP} step_kind_e;

  // arg is delay bits for K_DELAY and pop count for K_POP
  typedef struct {
    step_kind_e kind;
    ht_cmd_t    cmd;
    int         arg;
    int         exp_first;
    bit         exp_more;
  } step_t;

  logic                  clk_i;
  logic                  rst_i;
  ht_cmd_t               task_cmd_i;
  logic [KEY_WIDTH-1:0]  task_key_i;
  logic                  task_valid_i;
  logic                  task_ready_o;
  ht_cmd_t               result_cmd_o;
  ht_rescode_t           result_rescode_o;
  logic                  result_valid_o;
  logic                  result_ready_i;
  logic [B_W-1:0]        head_wr_addr_i;
  logic [A_W-1:0]        head_wr_ptr_i;
  logic                  head_wr_ptr_val_i;
  logic                  head_wr_en_i;
  logic [B_W-1:0]        head_rd_addr_i;
  logic [A_W-1:0]        head_rd_ptr_o;
  logic                  head_rd_ptr_val_o;
  logic [A_W-1:0]        data_wr_addr_i;
  logic [DATA_WIDTH-1:0] data_wr_data_i;
  logic                  data_wr_en_i;
  logic [A_W-1:0]        data_rd_addr_i;
  logic                  data_rd_en_i;
  logic [DATA_WIDTH-1:0] data_rd_data_o;
  logic                  empty_get_i;
  logic [A_W-1:0]        empty_ptr_o;
  logic                  empty_ptr_val_o;

  logic [31:0] lfsr_state = 32'h8a62_509d;
  int          errors = 0;
  int          cycles = 0;

  // partial pop in step 7 before a busy init that restarts the free list at 0
  step_t steps [NUM_STEPS] = '{
    '{K_PREFILL, OP_INIT,   0,       0, 1'b0},
    '{K_DELAY,   OP_INIT,   4,       0, 1'b0},
    '{K_INIT,    OP_INIT,   0,       0, 1'b0},
    '{K_POP,     OP_INIT,   D_DEPTH, 0, 1'b0},
    '{K_PREFILL, OP_INIT,   0,       0, 1'b0},
    '{K_DELAY,   OP_INIT,   3,       0, 1'b0},
    '{K_INIT,    OP_SEARCH, 0,       0, 1'b0},
    '{K_POP,     OP_INIT,   10,      0, 1'b1},
    '{K_BUSY,    OP_DELETE, 0,       0, 1'b0},
    '{K_POP,     OP_INIT,   D_DEPTH, 0, 1'b0}
  };

  hash_table_init_top #(
    .A_WIDTH      (A_W),
    .BUCKET_WIDTH (B_W)
  ) u_hash_table_init_top (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .task_cmd_i        (task_cmd_i),
    .task_key_i        (task_key_i),
    .task_valid_i      (task_valid_i),
    .task_ready_o      (task_ready_o),
    .result_cmd_o      (result_cmd_o),
    .result_rescode_o  (result_rescode_o),
    .result_valid_o    (result_valid_o),
    .result_ready_i    (result_ready_i),
    .head_wr_addr_i    (head_wr_addr_i),
    .head_wr_ptr_i     (head_wr_ptr_i),
    .head_wr_ptr_val_i (head_wr_ptr_val_i),
    .head_wr_en_i      (head_wr_en_i),
    .head_rd_addr_i    (head_rd_addr_i),
    .head_rd_ptr_o     (head_rd_ptr_o),
    .head_rd_ptr_val_o (head_rd_ptr_val_o),
    .data_wr_addr_i    (data_wr_addr_i),
    .data_wr_data_i    (data_wr_data_i),
    .data_wr_en_i      (data_wr_en_i),
    .data_rd_addr_i    (data_rd_addr_i),
    .data_rd_en_i      (data_rd_en_i),
    .data_rd_data_o    (data_rd_data_o),
    .empty_get_i       (empty_get_i),
    .empty_ptr_o       (empty_ptr_o),
    .empty_ptr_val_o   (empty_ptr_val_o)
  );

  bind data_table_init hash_table_init_props #(.A_WIDTH(A_WIDTH)) u_props (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .srst_i         (empty_ptr_storage_srst_o),
    .head_wr_en_i   (head_table_if.wr_en),
    .data_wr_en_i   (data_table_if.wr_en),
    .data_wr_addr_i (data_table_if.wr_addr),
    .add_en_i       (add_empty_ptr_en_o),
    .add_ptr_i      (add_empty_ptr_o),
    .res_valid_i    (ht_res_if.valid),
    .res_ready_i    (ht_res_if.ready),
    .res_result_i   (ht_res_if.result)
  );

  //--------------------
  // clock and timeout
  //--------------------

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  //--------------------
  // helpers
  //--------------------

  // taps 32 22 2 1 with one call per bit
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    errors++;
  endtask

  // stale valid heads and random records
  task automatic prefill_tables();
    for (int b = 0; b < H_DEPTH; b++)
    begin
      head_wr_addr_i    = B_W'(b);
      head_wr_ptr_i     = A_W'(rand_bits(A_W));
      head_wr_ptr_val_i = 1'b1;
      head_wr_en_i      = 1'b1;
      @(negedge clk_i);
    end
    head_wr_en_i = 1'b0;
    for (int a = 0; a < D_DEPTH; a++)
    begin
      data_wr_addr_i = A_W'(a);
      data_wr_data_i = rand_bits(DATA_WIDTH);
      data_wr_en_i   = 1'b1;
      @(negedge clk_i);
    end
    data_wr_en_i = 1'b0;
  endtask

  task automatic run_init(input ht_cmd_t cmd, input int delay, input bit offer_busy);
    int          busy_cycles;
    ht_cmd_t     got_cmd;
    ht_rescode_t got_code;
    busy_cycles = 0;
    if (task_ready_o !== 1'b1)
      report_mismatch("task_ready_o", task_ready_o, 1);
    task_cmd_i   = cmd;
    task_key_i   = KEY_WIDTH'(rand_bits(KEY_WIDTH));
    task_valid_i = 1'b1;
    @(negedge clk_i);
    task_valid_i = 1'b0;
    while (result_valid_o !== 1'b1)
    begin
      if (task_ready_o !== 1'b0)
        report_mismatch("task_ready_o", task_ready_o, 0);
      // second task offered in the middle of the sweep
      task_valid_i = offer_busy && (busy_cycles >= 2) && (busy_cycles < 6);
      task_cmd_i   = offer_busy ? OP_INSERT : cmd;
      busy_cycles++;
      @(negedge clk_i);
    end
    task_valid_i = 1'b0;
    got_cmd  = result_cmd_o;
    got_code = result_rescode_o;
    if (got_cmd !== cmd)
      report_mismatch("result_cmd_o", got_cmd, cmd);
    if (got_code !== INIT_SUCCESS)
      report_mismatch("result_rescode_o", got_code, INIT_SUCCESS);
    repeat (delay)
    begin
      @(negedge clk_i);
      if (result_valid_o !== 1'b1)
        report_mismatch("result_valid_o", result_valid_o, 1);
      if (result_cmd_o !== got_cmd)
        report_mismatch("result_cmd_o", result_cmd_o, got_cmd);
      if (result_rescode_o !== got_code)
        report_mismatch("result_rescode_o", result_rescode_o, got_code);
    end
    result_ready_i = 1'b1;
    @(negedge clk_i);
    result_ready_i = 1'b0;
    // engine idle again with nothing left over from the busy offer
    repeat (4)
    begin
      if (result_valid_o !== 1'b0)
        report_mismatch("result_valid_o", result_valid_o, 0);
      if (task_ready_o !== 1'b1)
        report_mismatch("task_ready_o", task_ready_o, 1);
      @(negedge clk_i);
    end
  endtask

  task automatic check_tables();
    for (int b = 0; b < H_DEPTH; b++)
    begin
      head_rd_addr_i = B_W'(b);
      @(negedge clk_i);
      if (head_rd_ptr_val_o !== 1'b0)
        report_mismatch("head_rd_ptr_val_o", head_rd_ptr_val_o, 0);
      if (head_rd_ptr_o !== '0)
        report_mismatch("head_rd_ptr_o", head_rd_ptr_o, 0);
    end
    data_rd_en_i = 1'b1;
    for (int a = 0; a < D_DEPTH; a++)
    begin
      data_rd_addr_i = A_W'(a);
      @(negedge clk_i);
      if (data_rd_data_o !== '0)
        report_mismatch("data_rd_data_o", data_rd_data_o, 0);
    end
    data_rd_en_i = 1'b0;
  endtask

  task automatic pop_and_check(input int n, input int first, input bit more);
    for (int i = 0; i < n; i++)
    begin
      if (empty_ptr_val_o !== 1'b1)
        report_mismatch("empty_ptr_val_o", empty_ptr_val_o, 1);
      if (empty_ptr_o !== A_W'(first + i))
        report_mismatch("empty_ptr_o", empty_ptr_o, first + i);
      empty_get_i = 1'b1;
      @(negedge clk_i);
    end
    empty_get_i = 1'b0;
    if (empty_ptr_val_o !== more)
      report_mismatch("empty_ptr_val_o", empty_ptr_val_o, more);
    if (more && (empty_ptr_o !== A_W'(first + n)))
      report_mismatch("empty_ptr_o", empty_ptr_o, first + n);
  endtask

  //--------------------
  // main sequence
  //--------------------

  initial
  begin
    int pending_bits;
    int delay;
    pending_bits      = 0;
    rst_i             = 1'b1;
    task_cmd_i        = OP_INIT;
    task_key_i        = '0;
    task_valid_i      = 1'b0;
    result_ready_i    = 1'b0;
    head_wr_addr_i    = '0;
    head_wr_ptr_i     = '0;
    head_wr_ptr_val_i = 1'b0;
    head_wr_en_i      = 1'b0;
    head_rd_addr_i    = '0;
    data_wr_addr_i    = '0;
    data_wr_data_i    = '0;
    data_wr_en_i      = 1'b0;
    data_rd_addr_i    = '0;
    data_rd_en_i      = 1'b0;
    empty_get_i       = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    if (task_ready_o !== 1'b1)
      report_mismatch("task_ready_o", task_ready_o, 1);
    if (result_valid_o !== 1'b0)
      report_mismatch("result_valid_o", result_valid_o, 0);
    if (empty_ptr_val_o !== 1'b0)
      report_mismatch("empty_ptr_val_o", empty_ptr_val_o, 0);

    for (int s = 0; s < NUM_STEPS; s++)
    begin
      case (steps[s].kind)
        K_PREFILL:
          prefill_tables();
        K_DELAY:
          pending_bits = steps[s].arg;
        K_INIT, K_BUSY:
        begin
          delay = (pending_bits > 0) ? 1 + int'(rand_bits(pending_bits)) : 0;
          run_init(steps[s].cmd, delay, steps[s].kind == K_BUSY);
          check_tables();
          pending_bits = 0;
        end
        K_POP:
          pop_and_check(steps[s].arg, steps[s].exp_first, steps[s].exp_more);
        default:
          pending_bits = 0;
      endcase
    end

    $display("%0d steps run, %0d errors", NUM_STEPS, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: build.f
ht_cfg_pkg.sv
ht_cmd_pkg.sv
ht_ifs.sv
data_table_init.sv
head_table.sv
data_table.sv
empty_ptr_storage.sv
hash_table_init_top.sv
hash_table_init_props.sv
tb_hash_table_init.sv

// File: Makefile
# Verilator build and run for the hash table init testbench

VERILATOR ?= verilator
TOP       ?= tb_hash_table_init
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := Test failures found
PASS_MSG := All tests passed!
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
